//--- build.f
+incdir+hdl
+incdir+verification
hdl/stream_pkg.sv
hdl/srl_queue.sv
hdl/stream_merge_arbiter.sv
hdl/stream_merge_top.sv
verification/stream_merge_tb.sv

//--- Makefile
# Verilator build, run and lint for the stream merge project

VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= stream_merge_tb
RTL_TOP    ?= stream_merge_top
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# the run fails unless the pass line shows up in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- verification/stream_merge_model.svh
// stream merge reference model, included inside the testbench module
// expected words per source, packet ownership and alternation rules

`ifndef STREAM_MERGE_MODEL_SVH
`define STREAM_MERGE_MODEL_SVH

stream_word_t expected_0[$];              // accepted on channel 0, not yet out
stream_word_t expected_1[$];              // same for channel 1
int           mismatches  = 0;
logic         in_packet   = 1'b0;         // last output word had no end flag
src_t         owner       = 1'b0;         // source that owns the open packet
logic         alt_mode    = 1'b0;         // both producers saturated, sink ready
logic         have_last   = 1'b0;
src_t         last_src    = 1'b0;         // source of the previous packet
int           alt_packets = 0;            // packets closed while alt_mode was set

// every accepted input word joins the queue of its own source
task automatic record_input(input src_t src, input stream_word_t word);
   if (src) begin
      expected_1.push_back(word);
   end else begin
      expected_0.push_back(word);
   end
endtask

// one output transfer against the head of the queue that o_src names
task automatic check_output(input src_t src, input stream_word_t word);
   stream_word_t want;
   logic         eop;
   eop = word[$bits(payload_t)];          // end flag sits above the payload
   if (src ? (expected_1.size() == 0) : (expected_0.size() == 0)) begin
      mismatches++;
      $display("source %0d sent word %h while nothing was queued for it", src, word);
   end else begin
      if (src) begin
         want = expected_1.pop_front();
      end else begin
         want = expected_0.pop_front();
      end
      if (word !== want) begin
         mismatches++;
         $display("** Error order: source %0d expected %h, actual %h", src, want, word);
      end
   end
   // an open packet keeps the output until its end word
   if (in_packet && src != owner) begin
      mismatches++;
      $display("** Error atomicity: expected source %0d, actual %0d", owner, src);
   end
   in_packet = !eop;
   owner     = src;
   if (alt_mode && eop) begin
      if (have_last && src == last_src) begin
         mismatches++;
         $display("** Error alternation: expected source %0d, actual %0d", !last_src, src);
      end
      have_last = 1'b1;
      last_src  = src;
      alt_packets++;
   end
endtask

`endif

//--- verification/stream_merge_tb.sv
// stream merge testbench
// lfsr driven traffic on both channels checked by a reference model,
// plus reset, fullness, alternation and drain scenarios

`timescale 1ns/1ps
`include "stream_macros.svh"

module stream_merge_tb;

   import stream_pkg::*;

   localparam int step_limit = 2000;      // cycles allowed for any single wait

   logic         clock;
   logic         reset;
   stream_word_t i_data_0;
   stream_word_t i_data_1;
   logic         i_valid_0;
   logic         i_valid_1;
   logic         o_busy_0;
   logic         o_busy_1;
   stream_word_t o_data;
   src_t         o_src;
   logic         o_valid;
   logic         i_busy;

   int           errors    = 0;            // driver side failures
   logic         timed_out = 1'b0;         // later phases are skipped once set
   logic [31:0]  lfsr      = 32'h7a0e;
   logic         take_0;                   // offered word goes in on the next edge
   logic         take_1;

   `include "stream_merge_model.svh"

   stream_merge_top stream_merge_top_inst (
      .clock     (clock),
      .reset     (reset),
      .i_data_0  (i_data_0),
      .i_data_1  (i_data_1),
      .i_valid_0 (i_valid_0),
      .i_valid_1 (i_valid_1),
      .o_busy_0  (o_busy_0),
      .o_busy_1  (o_busy_1),
      .o_data    (o_data),
      .o_src     (o_src),
      .o_valid   (o_valid),
      .i_busy    (i_busy)
   );

   initial begin
      clock = 1'b0;
      forever #4 clock = ~clock;           // 8 ns period
   end

   // galois lfsr, stepped once for each bit handed out
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int k = 0; k < n; k++) begin
         r    = {r[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      end
      return r;
   endfunction

   function automatic stream_word_t random_word();
      payload_t data;
      logic     eop;
      data = payload_t'(rand_bits($bits(payload_t)));
      eop  = (rand_bits(2) == 0);          // roughly one word in four ends a packet
      return {eop, data};
   endfunction

   function automatic logic busy_of(input src_t ch);
      return ch ? o_busy_1 : o_busy_0;
   endfunction

   function automatic void offer(input src_t ch, input logic valid, input stream_word_t word);
      if (ch) begin
         i_valid_1 = valid;
         i_data_1  = word;
      end else begin
         i_valid_0 = valid;
         i_data_0  = word;
      end
   endfunction

   task automatic next_cycle();
      @(posedge clock);
      #1;                                  // inputs change just after the edge
   endtask

   // sample at the falling edge, everything is settled for the next rising edge
   always @(negedge clock) begin
      if (!alt_mode) have_last = 1'b0;
      if (reset) begin
         if (i_valid_0 && !o_busy_0) record_input(1'b0, i_data_0);
         if (i_valid_1 && !o_busy_1) record_input(1'b1, i_data_1);
         if (o_valid && !i_busy) check_output(o_src, o_data);
      end
   end

   task automatic check_idle_outputs();
      if (o_valid || o_busy_0 || o_busy_1) begin
         errors++;
         $display("** Error reset: expected 000, actual %b%b%b", o_valid, o_busy_0, o_busy_1);
      end
   endtask

   // producers keep an unaccepted word until it goes in
   task automatic random_traffic(input int cycles);
      for (int c = 0; c < cycles; c++) begin
         next_cycle();
         if (!i_valid_0 || take_0) offer(1'b0, rand_bits(2) != 0, random_word());
         if (!i_valid_1 || take_1) offer(1'b1, rand_bits(2) != 0, random_word());
         i_busy = (rand_bits(2) == 0);
         take_0 = i_valid_0 && !o_busy_0;
         take_1 = i_valid_1 && !o_busy_1;
      end
   endtask

   task automatic saturated_traffic(input int cycles);
      int start;
      start    = alt_packets;
      alt_mode = 1'b1;
      for (int c = 0; c < cycles; c++) begin
         next_cycle();
         if (!i_valid_0 || take_0) offer(1'b0, 1'b1, random_word());
         if (!i_valid_1 || take_1) offer(1'b1, 1'b1, random_word());
         i_busy = 1'b0;
         take_0 = !o_busy_0;
         take_1 = !o_busy_1;
      end
      alt_mode = 1'b0;
      if (alt_packets - start < 8) begin
         errors++;
         $display("only %0d packets finished with both producers saturated", alt_packets - start);
      end
   endtask

   // sink stalled, one channel offers words until its queue reports full
   task automatic fill_check(input src_t ch, input int depth);
      int accepted;
      int n;
      accepted = 0;
      n        = 0;
      next_cycle();
      i_busy   = 1'b1;
      while (!busy_of(ch) && n < step_limit) begin
         offer(ch, 1'b1, random_word());
         accepted++;
         next_cycle();
         n++;
      end
      if (!busy_of(ch)) begin
         errors++;
         timed_out = 1'b1;
         $display("timeout: channel %0d never reported full", ch);
      end else if (accepted != depth) begin
         errors++;
         $display("** Error fullness: expected %0d, actual %0d", depth, accepted);
      end
      repeat (4) begin                      // valid stays high, busy must hold
         next_cycle();
         if (!busy_of(ch)) begin
            errors++;
            $display("** Error fullness: expected busy 1, actual 0 on channel %0d", ch);
         end
      end
      offer(ch, 1'b0, '0);
   endtask

   // both producers send an end word together, so whichever channel
   // holds the grant can finish its packet while the other one waits
   task automatic close_packets();
      logic pend_0;
      logic pend_1;
      logic go_0;
      logic go_1;
      int   n;
      pend_0 = 1'b1;
      pend_1 = 1'b1;
      n      = 0;
      next_cycle();
      offer(1'b0, 1'b1, {1'b1, payload_t'(rand_bits($bits(payload_t)))});
      offer(1'b1, 1'b1, {1'b1, payload_t'(rand_bits($bits(payload_t)))});
      while ((pend_0 || pend_1) && n < step_limit) begin
         go_0 = pend_0 && !o_busy_0;        // busy is registered, holds until the edge
         go_1 = pend_1 && !o_busy_1;
         next_cycle();
         n++;
         if (go_0) begin
            pend_0 = 1'b0;
            offer(1'b0, 1'b0, '0);
         end
         if (go_1) begin
            pend_1 = 1'b0;
            offer(1'b1, 1'b0, '0);
         end
      end
      if (pend_0 || pend_1) begin
         errors++;
         timed_out = 1'b1;
         $display("timeout: end word still not accepted after %0d cycles", step_limit);
         offer(1'b0, 1'b0, '0);
         offer(1'b1, 1'b0, '0);
      end
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while ((expected_0.size() != 0 || expected_1.size() != 0) && n < step_limit) begin
         next_cycle();
         n++;
      end
      if (expected_0.size() != 0 || expected_1.size() != 0) begin
         errors++;
         timed_out = 1'b1;
         $display("timeout: queued words never reached the output");
      end
      repeat (16) begin
         @(negedge clock);
         if (o_valid) begin
            errors++;
            $display("** Error drain: expected o_valid 0, actual 1");
         end
      end
   endtask

   // stop both producers, end any open packet and empty the design
   task automatic settle();
      next_cycle();
      offer(1'b0, 1'b0, '0);
      offer(1'b1, 1'b0, '0);
      i_busy = 1'b0;
      take_0 = 1'b0;
      take_1 = 1'b0;
      close_packets();
      wait_drain();
   endtask

   initial begin
      reset     = 1'b0;
      i_data_0  = '0;
      i_data_1  = '0;
      i_valid_0 = 1'b0;
      i_valid_1 = 1'b0;
      i_busy    = 1'b0;
      take_0    = 1'b0;
      take_1    = 1'b0;
      repeat (8) begin
         @(negedge clock);
         check_idle_outputs();
      end
      next_cycle();
      reset = 1'b1;
      @(negedge clock);
      check_idle_outputs();                // first cycle out of reset
      random_traffic(3000);
      settle();
      if (!timed_out) fill_check(1'b0, `STREAM_DEPTH_A);
      if (!timed_out) settle();
      if (!timed_out) fill_check(1'b1, `STREAM_DEPTH_B);
      if (!timed_out) settle();
      if (!timed_out) saturated_traffic(600);
      if (!timed_out) settle();
      if (!timed_out) random_traffic(2000);
      if (!timed_out) settle();
      $display("summary: %0d model mismatches, %0d other errors", mismatches, errors);
      if (mismatches == 0 && errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

//--- hdl/stream_merge_top.sv
// stream merge top: two buffered channels merged onto one tagged stream
// channel 0 queue is shallow, channel 1 queue is deep

`timescale 1ns/1ps
`include "stream_macros.svh"

module stream_merge_top (
   input  logic                    clock,
   input  logic                    reset,
   input  stream_pkg::stream_word_t i_data_0,
   input  stream_pkg::stream_word_t i_data_1,
   input  logic                    i_valid_0,
   input  logic                    i_valid_1,
   output logic                    o_busy_0,
   output logic                    o_busy_1,
   output stream_pkg::stream_word_t o_data,
   output stream_pkg::src_t        o_src,
   output logic                    o_valid,
   input  logic                    i_busy
);

   import stream_pkg::*;

   stream_word_t q_data_0, q_data_1;    // queue heads into the arbiter
   logic         q_valid_0, q_valid_1;
   logic         q_busy_0, q_busy_1;    // grant back-pressure per queue

   srl_queue #(.depth(`STREAM_DEPTH_A)) queue_0_inst (
      .clock   (clock),
      .reset   (reset),
      .i_data  (i_data_0),
      .i_valid (i_valid_0),
      .o_busy  (o_busy_0),
      .o_data  (q_data_0),
      .o_valid (q_valid_0),
      .i_busy  (q_busy_0)
   );

   srl_queue #(.depth(`STREAM_DEPTH_B)) queue_1_inst (
      .clock   (clock),
      .reset   (reset),
      .i_data  (i_data_1),
      .i_valid (i_valid_1),
      .o_busy  (o_busy_1),
      .o_data  (q_data_1),
      .o_valid (q_valid_1),
      .i_busy  (q_busy_1)
   );

   stream_merge_arbiter arbiter_inst (
      .clock     (clock),
      .reset     (reset),
      .i_data_0  (q_data_0),
      .i_data_1  (q_data_1),
      .i_valid_0 (q_valid_0),
      .i_valid_1 (q_valid_1),
      .o_busy_0  (q_busy_0),
      .o_busy_1  (q_busy_1),
      .o_data    (o_data),
      .o_src     (o_src),
      .o_valid   (o_valid),
      .i_busy    (i_busy)
   );

endmodule

//--- hdl/stream_merge_arbiter.sv
// stream merge arbiter: packet-atomic round-robin over two streams
// forwards the granted stream combinationally and tags it with its source

`timescale 1ns/1ps

module stream_merge_arbiter (
   input  logic                    clock,
   input  logic                    reset,
   input  stream_pkg::stream_word_t i_data_0,
   input  stream_pkg::stream_word_t i_data_1,
   input  logic                    i_valid_0,
   input  logic                    i_valid_1,
   output logic                    o_busy_0,
   output logic                    o_busy_1,
   output stream_pkg::stream_word_t o_data,
   output stream_pkg::src_t        o_src,
   output logic                    o_valid,
   input  logic                    i_busy
);

   import stream_pkg::*;

   merge_state_e state;
   src_t         rr_ptr;                  // favored channel when both are valid
   src_t         sel;                     // channel driving the output this cycle
   logic         xfer;                    // word leaves on this edge
   logic         eop;

   // grant decision, only free to move while no packet is open
   always_comb begin
      unique case (state)
         m_hold0: sel = 1'b0;
         m_hold1: sel = 1'b1;
         default: begin
            if (i_valid_0 && i_valid_1) begin
               sel = rr_ptr;
            end else begin
               sel = i_valid_1;          // lone valid wins, idle falls to 0
            end
         end
      endcase
   end

   assign o_data   = sel ? i_data_1 : i_data_0;
   assign o_valid  = sel ? i_valid_1 : i_valid_0;
   assign o_src    = sel;
   assign o_busy_0 = sel ? 1'b1 : i_busy;   // loser is held off
   assign o_busy_1 = sel ? i_busy : 1'b1;

   assign xfer = o_valid && !i_busy;
   assign eop  = o_data[$bits(payload_t)];  // end flag above the payload

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         state  <= m_open;
         rr_ptr <= 1'b0;
      end else if (xfer) begin
         if (eop) begin
            state  <= m_open;
            rr_ptr <= ~sel;                  // other channel goes first next time
         end else begin
            state  <= sel ? m_hold1 : m_hold0;
         end
      end
   end

endmodule

//--- hdl/srl_queue.sv
// srl queue: shift-chain stream buffer with a registered output
// input and output flow control are decoupled, busy is an address compare

`timescale 1ns/1ps

module srl_queue #(
   parameter int depth = 16                          // max words held, 2 to 256
) (
   input  logic                    clock,
   input  logic                    reset,
   input  stream_pkg::stream_word_t i_data,           // producer side
   input  logic                    i_valid,
   output logic                    o_busy,
   output stream_pkg::stream_word_t o_data,           // consumer side
   output logic                    o_valid,
   input  logic                    i_busy
);

   import stream_pkg::*;

   localparam int addr_bits = $clog2(depth);          // indexes chain entries 0..depth-2

   stream_word_t         chain [0:depth-2];           // shift chain, no reset
   stream_word_t         out_reg;                     // head word
   stream_word_t         out_next;
   logic                 load_out;                    // refill head register
   logic                 shift_en;                    // push i_data into chain
   logic [addr_bits-1:0] addr;                        // oldest chain entry
   logic [addr_bits-1:0] addr_next;
   logic                 addr_zero;                   // addr==0, registered
   logic                 full;
   queue_state_e         state;
   queue_state_e         state_next;

   // depth words held: head reg plus a full chain
   assign full    = (state == q_more) && (addr == addr_bits'(depth - 2));
   assign o_busy  = full;
   assign o_valid = (state != q_empty);
   assign o_data  = out_reg;                          // keeps last word while empty

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         state     <= q_empty;
         addr      <= '0;
         addr_zero <= 1'b1;
      end else begin
         state     <= state_next;
         addr      <= addr_next;
         addr_zero <= (addr_next == '0);              // precomputed for next cycle
      end
   end

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         out_reg <= '0;
      end else if (load_out) begin
         out_reg <= out_next;
      end
   end

   // newest word enters at index 0, oldest moves toward depth-2
   always_ff @(posedge clock) begin
      if (shift_en) begin
         for (int i = depth - 2; i > 0; i--) begin
            chain[i] <= chain[i-1];
         end
         chain[0] <= i_data;
      end
   end

   always_comb begin
      state_next = state;
      addr_next  = addr;
      shift_en   = 1'b0;
      load_out   = 1'b0;
      out_next   = i_data;
      unique case (state)
         q_empty: begin
            addr_next = '0;
            if (i_valid) begin                        // straight into head reg
               load_out   = 1'b1;
               state_next = q_one;
            end
         end
         q_one: begin
            addr_next = '0;
            if (i_valid && i_busy) begin              // head stalled, word to chain
               shift_en   = 1'b1;
               state_next = q_more;
            end else if (i_valid) begin               // head leaves, new word replaces it
               load_out   = 1'b1;
            end else if (!i_busy) begin               // head leaves, nothing behind
               state_next = q_empty;
            end
         end
         q_more: begin
            if (full) begin
               // no input accepted while full
               if (!i_busy) begin
                  load_out   = 1'b1;
                  out_next   = chain[addr];
                  addr_next  = addr_zero ? '0 : addr - 1'b1;
                  state_next = addr_zero ? q_one : q_more;
               end
            end else if (i_valid && i_busy) begin     // fill only
               shift_en  = 1'b1;
               addr_next = addr + 1'b1;
            end else if (i_valid) begin               // fill and drain, count holds
               shift_en = 1'b1;
               load_out = 1'b1;
               out_next = chain[addr];
            end else if (!i_busy) begin               // drain only
               load_out   = 1'b1;
               out_next   = chain[addr];
               addr_next  = addr_zero ? '0 : addr - 1'b1;
               state_next = addr_zero ? q_one : q_more;
            end
         end
         default: begin
            state_next = q_empty;
            addr_next  = '0;
         end
      endcase
   end

endmodule

//--- hdl/stream_pkg.sv
// stream merge shared types
// word layout, source tag and the controller state encodings

`include "stream_macros.svh"

package stream_pkg;

   typedef logic [`STREAM_DATA_BITS-1:0] payload_t;   // data part of a word

   // end-of-packet flag concatenated on top of the payload
   typedef logic [$bits(payload_t):0] stream_word_t;

   typedef logic src_t;                                // source tag, channel 0 or 1

   // queue controller, item count is 0, 1 or chain addr + 2
   typedef enum logic [1:0] {
      q_empty,
      q_one,
      q_more
   } queue_state_e;

   typedef enum logic [1:0] {
      m_open,    // no packet in flight, round-robin decides
      m_hold0,   // channel 0 owns the output until its end word
      m_hold1    // same for channel 1
   } merge_state_e;

endpackage

//--- hdl/stream_macros.svh
// stream merge build constants
// payload width and the depths of the two channel queues

`ifndef STREAM_MACROS_SVH
`define STREAM_MACROS_SVH

// data bits per word, the end flag sits just above them
`define STREAM_DATA_BITS 16

// channel 0 queue, kept shallow so it fills fast
`define STREAM_DEPTH_A 4

// channel 1 queue
`define STREAM_DEPTH_B 16

`endif
